/* source/ifu_macros.svh */
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

`define IFU_ADDR_W 32
`define IFU_SETS 4
`define IFU_LINE_WORDS 2
`define IFU_IDX_W 2
`define IFU_OFF_W 1
`define IFU_PC_INIT 32'h8000_0000

// RV32I major opcodes
`define IFU_OP_JAL 7'b1101111
`define IFU_OP_JALR 7'b1100111
`define IFU_OP_BRANCH 7'b1100011
`define IFU_OP_SYSTEM 7'b1110011
`define IFU_OP_MISC_MEM 7'b0001111

`define IFU_FUNCT3_FENCE_I 3'b001

`endif

/* source/ifu_pkg.sv */
`include "ifu_macros.svh"

package ifu_pkg;

  // Instruction or bus data word
  typedef logic [`IFU_ADDR_W-1:0] word_t;

  // Byte address
  typedef logic [`IFU_ADDR_W-1:0] addr_t;

  // Address bits above index, offset and byte select
  typedef logic [`IFU_ADDR_W-`IFU_IDX_W-`IFU_OFF_W-3:0] tag_t;

  typedef logic [`IFU_IDX_W-1:0] idx_t;

  typedef logic [`IFU_OFF_W-1:0] off_t;

  // Fetch / refill states
  typedef enum logic [1:0] {
    LOOKUP = 2'd0,
    REQ    = 2'd1,
    WAIT   = 2'd2
  } refill_state_e;

endpackage

/* source/icache_if.sv */
`timescale 1ns/1ns

interface icache_if;
  ifu_pkg::idx_t  lookup_idx;
  ifu_pkg::tag_t  lookup_tag;
  ifu_pkg::off_t  lookup_off;
  logic           hit;
  ifu_pkg::word_t rd_data;
  logic           fill_we;
  ifu_pkg::off_t  fill_off;
  ifu_pkg::word_t fill_data;
  logic           inval;

  modport array (
    input  lookup_idx, lookup_tag, lookup_off,
    input  fill_we, fill_off, fill_data, inval,
    output hit, rd_data
  );

  modport ctrl (
    input  lookup_idx, lookup_tag, hit,
    output fill_we, fill_off, fill_data
  );

  modport pc (output lookup_idx, lookup_tag, lookup_off, inval);
endinterface

/* source/icache_array.sv */
`timescale 1ns/1ns
`include "ifu_macros.svh"

module icache_array (
  input logic      clk,
  input logic      rst,
  icache_if.array  cache
);

  ifu_pkg::tag_t       tag_q   [`IFU_SETS];
  ifu_pkg::word_t      data_q  [`IFU_SETS][`IFU_LINE_WORDS];
  logic [`IFU_SETS-1:0] valid_q;

  logic fill_last;

  // Refill runs word 0 upward, so the top word closes the line
  assign fill_last = (cache.fill_off == ifu_pkg::off_t'(`IFU_LINE_WORDS - 1));

  assign cache.hit = valid_q[cache.lookup_idx] &&
                     (tag_q[cache.lookup_idx] == cache.lookup_tag);
  assign cache.rd_data = data_q[cache.lookup_idx][cache.lookup_off];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (cache.inval) begin
      valid_q <= '0; // Flash invalidate
    end else if (cache.fill_we) begin
      valid_q[cache.lookup_idx] <= fill_last; // Line invalid while partly filled
    end
  end

  always_ff @(posedge clk) begin
    if (cache.fill_we && fill_last) begin
      tag_q[cache.lookup_idx] <= cache.lookup_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (cache.fill_we) begin
      data_q[cache.lookup_idx][cache.fill_off] <= cache.fill_data;
    end
  end

endmodule

/* source/refill_counter.sv */
`timescale 1ns/1ns
`include "ifu_macros.svh"

module refill_counter (
  input  logic          clk,
  input  logic          rst,
  input  logic          start_i,
  input  logic          beat_i,
  output ifu_pkg::off_t off_o,
  output logic          last_o
);

  ifu_pkg::off_t off_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      off_q <= '0;
    end else if (start_i) begin
      off_q <= '0; // New line starts at word 0
    end else if (beat_i) begin
      off_q <= off_q + 1'b1;
    end
  end

  assign off_o  = off_q;
  assign last_o = (off_q == ifu_pkg::off_t'(`IFU_LINE_WORDS - 1));

endmodule

/* source/fetch_fsm.sv */
`timescale 1ns/1ns

module fetch_fsm (
  input  logic           clk,
  input  logic           rst,
  icache_if.ctrl         cache,
  input  logic           stall_i,
  input  logic           ready_i,
  input  logic           rvalid_i,
  input  ifu_pkg::word_t rdata_i,
  output ifu_pkg::addr_t araddr_o,
  output logic           arvalid_o,
  output logic           valid_o,
  output logic           accept_o,
  output logic           cnt_start_o,
  output logic           cnt_beat_o,
  input  ifu_pkg::off_t  cnt_off_i,
  input  logic           cnt_last_i
);

  ifu_pkg::refill_state_e state_q;
  ifu_pkg::refill_state_e state_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ifu_pkg::LOOKUP;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d         = state_q;
    cnt_start_o     = 1'b0;
    cnt_beat_o      = 1'b0;
    cache.fill_we   = 1'b0;
    case (state_q)
      ifu_pkg::LOOKUP: begin
        // No refill while parked on a control-flow instruction
        if (!cache.hit && !stall_i) begin
          state_d     = ifu_pkg::REQ;
          cnt_start_o = 1'b1;
        end
      end
      ifu_pkg::REQ: begin
        state_d = ifu_pkg::WAIT;
      end
      ifu_pkg::WAIT: begin
        if (rvalid_i) begin
          cache.fill_we = 1'b1;
          cnt_beat_o    = 1'b1;
          if (cnt_last_i) begin
            state_d = ifu_pkg::LOOKUP; // Line complete
          end else begin
            state_d = ifu_pkg::REQ; // Next word of line
          end
        end
      end
      default: begin
        state_d = ifu_pkg::LOOKUP;
      end
    endcase
  end

  assign cache.fill_off  = cnt_off_i;
  assign cache.fill_data = rdata_i;

  // Word address inside the missing line
  assign araddr_o  = {cache.lookup_tag, cache.lookup_idx, cnt_off_i, 2'b00};
  assign arvalid_o = (state_q == ifu_pkg::REQ);

  assign valid_o  = (state_q == ifu_pkg::LOOKUP) && cache.hit && !stall_i;
  assign accept_o = valid_o && ready_i;

endmodule

/* source/fetch_pc.sv */
`timescale 1ns/1ns
`include "ifu_macros.svh"

module fetch_pc (
  input  logic           clk,
  input  logic           rst,
  icache_if.pc           cache,
  input  logic           accept_i,
  input  ifu_pkg::word_t inst_i,
  input  logic           redirect_i,
  input  ifu_pkg::addr_t npc_i,
  output logic           stall_o,
  output ifu_pkg::addr_t pc_o
);

  ifu_pkg::addr_t pc_q;
  logic           stall_q;
  logic [6:0]     opcode;
  logic [2:0]     funct3;
  logic           is_ctrl;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];

  assign is_ctrl = (opcode == `IFU_OP_JAL) || (opcode == `IFU_OP_JALR) ||
                   (opcode == `IFU_OP_BRANCH) || (opcode == `IFU_OP_SYSTEM);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= `IFU_PC_INIT;
      stall_q <= 1'b0;
    end else if (redirect_i && stall_q) begin
      pc_q    <= npc_i; // Target from core
      stall_q <= 1'b0;
    end else if (accept_i) begin
      if (is_ctrl) begin
        stall_q <= 1'b1; // Wait for redirect
      end else begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  assign cache.inval = accept_i && (opcode == `IFU_OP_MISC_MEM) &&
                       (funct3 == `IFU_FUNCT3_FENCE_I);

  // PC split for the direct-mapped lookup
  assign cache.lookup_tag = pc_q[`IFU_ADDR_W-1:`IFU_IDX_W+`IFU_OFF_W+2];
  assign cache.lookup_idx = pc_q[`IFU_IDX_W+`IFU_OFF_W+1:`IFU_OFF_W+2];
  assign cache.lookup_off = pc_q[`IFU_OFF_W+1:2];

  assign stall_o = stall_q;
  assign pc_o    = pc_q;

endmodule

/* source/ifu_top.sv */
`timescale 1ns/1ns

module ifu_top (
  input  logic           clk,
  input  logic           rst,
  output ifu_pkg::addr_t araddr_o,
  output logic           arvalid_o,
  input  ifu_pkg::word_t rdata_i,
  input  logic           rvalid_i,
  input  ifu_pkg::addr_t npc_i,
  input  logic           redirect_i,
  output ifu_pkg::word_t inst_o,
  output ifu_pkg::addr_t pc_o,
  output logic           valid_o,
  input  logic           ready_i
);

  icache_if cache_bus ();

  logic          stall;
  logic          accept;
  logic          cnt_start;
  logic          cnt_beat;
  ifu_pkg::off_t cnt_off;
  logic          cnt_last;

  icache_array u_array (
    .clk   (clk),
    .rst   (rst),
    .cache (cache_bus)
  );

  refill_counter u_cnt (
    .clk     (clk),
    .rst     (rst),
    .start_i (cnt_start),
    .beat_i  (cnt_beat),
    .off_o   (cnt_off),
    .last_o  (cnt_last)
  );

  fetch_fsm u_fsm (
    .clk         (clk),
    .rst         (rst),
    .cache       (cache_bus),
    .stall_i     (stall),
    .ready_i     (ready_i),
    .rvalid_i    (rvalid_i),
    .rdata_i     (rdata_i),
    .araddr_o    (araddr_o),
    .arvalid_o   (arvalid_o),
    .valid_o     (valid_o),
    .accept_o    (accept),
    .cnt_start_o (cnt_start),
    .cnt_beat_o  (cnt_beat),
    .cnt_off_i   (cnt_off),
    .cnt_last_i  (cnt_last)
  );

  fetch_pc u_pc (
    .clk        (clk),
    .rst        (rst),
    .cache      (cache_bus),
    .accept_i   (accept),
    .inst_i     (cache_bus.rd_data),
    .redirect_i (redirect_i),
    .npc_i      (npc_i),
    .stall_o    (stall),
    .pc_o       (pc_o)
  );

  assign inst_o = cache_bus.rd_data;

endmodule

/* tb/tb_ifu.sv */
`timescale 1ns/1ns
`include "ifu_macros.svh"

module tb_ifu;
  localparam int NUM_INST   = 400;
  localparam int WORST_CYC  = 20; // Two-beat refill at max latency plus redirect delay
  localparam int TIMEOUT_NS = NUM_INST * WORST_CYC * 10 * 3;

  logic clk, rst, arvalid_o, rvalid_i, redirect_i, valid_o, ready_i;
  ifu_pkg::addr_t araddr_o, npc_i, pc_o;
  ifu_pkg::word_t rdata_i, inst_o;

  ifu_pkg::word_t image [256];
  logic [31:0] lfsr = 32'had68;
  logic [3:0] sh_valid = '0; // Shadow cache
  ifu_pkg::tag_t sh_tag [4];
  ifu_pkg::addr_t exp_pc = `IFU_PC_INIT;
  ifu_pkg::addr_t req_addr, mon_addr, prev_pc;
  ifu_pkg::word_t prev_inst;
  logic mon_req = 1'b0, mon_ctrl = 1'b0, cf_wait = 1'b0, req_half = 1'b0, hold_chk = 1'b0;
  int n_accept = 0, n_word_err = 0, n_addr_err = 0, n_flag_err = 0;

  ifu_top u_dut (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic ifu_pkg::word_t exp_inst(input ifu_pkg::addr_t pc);
    return image[pc[9:2]];
  endfunction

  function automatic logic is_ctrl_inst(input ifu_pkg::word_t w);
    return (w[6:0] == `IFU_OP_JAL) || (w[6:0] == `IFU_OP_JALR) ||
           (w[6:0] == `IFU_OP_BRANCH) || (w[6:0] == `IFU_OP_SYSTEM);
  endfunction

  function automatic logic is_fence_i(input ifu_pkg::word_t w);
    return (w[6:0] == `IFU_OP_MISC_MEM) && (w[14:12] == `IFU_FUNCT3_FENCE_I);
  endfunction

  function automatic logic shadow_hit(input ifu_pkg::addr_t pc);
    return sh_valid[pc[4:3]] && (sh_tag[pc[4:3]] == pc[31:5]);
  endfunction

  task automatic check_word(input string name, input ifu_pkg::word_t got, exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
      n_word_err++;
    end
  endtask

  task automatic check_addr(input string name, input ifu_pkg::addr_t got, exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
      n_addr_err++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
      n_flag_err++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Stimulus for image, reset, memory, ready and redirect
  initial begin
    int wait_cnt;
    int redir_cnt;
    logic [31:0] r;
    wait_cnt = 0;
    redir_cnt = 0;
    rst <= 1'b1;
    ready_i <= 1'b0;
    rvalid_i <= 1'b0;
    rdata_i <= '0;
    redirect_i <= 1'b0;
    npc_i <= '0;
    for (int a = 0; a < 256; a++) begin
      r = rand_bits(3);
      if (r == 0) begin
        r = rand_bits(25);
        image[a] = {r[24:5], r[4:0], `IFU_OP_JAL};
      end else if (r == 1) begin
        image[a] = {17'd0, `IFU_FUNCT3_FENCE_I, 5'd0, `IFU_OP_MISC_MEM};
      end else begin
        r = rand_bits(22);
        image[a] = {r[21:10], r[9:5], 3'b000, r[4:0], 7'b0010011}; // addi
      end
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    forever begin
      @(posedge clk);
      rvalid_i <= 1'b0;
      redirect_i <= 1'b0;
      ready_i <= (rand_bits(2) != 0);
      if (mon_req) begin
        wait_cnt = 1 + rand_bits(2);
        req_addr = mon_addr;
      end
      if (wait_cnt > 0) begin
        wait_cnt--;
        if (wait_cnt == 0) begin
          rvalid_i <= 1'b1;
          rdata_i <= image[req_addr[9:2]];
        end
      end
      if (mon_ctrl) redir_cnt = 1 + rand_bits(3);
      if (redir_cnt > 0) begin
        redir_cnt--;
        if (redir_cnt == 0) begin
          redirect_i <= 1'b1;
          npc_i <= `IFU_PC_INIT + (rand_bits(5) << 2); // Back into the first 32 words
        end
      end
    end
  end

  // Compare process sampled mid-cycle
  always @(negedge clk) begin
    ifu_pkg::addr_t line_addr;
    ifu_pkg::word_t inst;
    if (!rst) begin
      mon_req = arvalid_o;
      mon_addr = araddr_o;
      mon_ctrl = 1'b0;
      if (hold_chk) begin
        check_flag("valid_o", valid_o, 1'b1);
        check_word("inst_o", inst_o, prev_inst);
        check_addr("pc_o", pc_o, prev_pc);
      end
      hold_chk = valid_o && !ready_i;
      prev_inst = inst_o;
      prev_pc = pc_o;
      if (arvalid_o) begin
        line_addr = {pc_o[31:3], 3'b000};
        if (!req_half) begin
          check_flag("arvalid_o", 1'b1, !shadow_hit(pc_o));
          check_addr("araddr_o", araddr_o, line_addr);
        end else begin
          check_addr("araddr_o", araddr_o, line_addr + 32'd4);
          sh_valid[line_addr[4:3]] = 1'b1;
          sh_tag[line_addr[4:3]] = line_addr[31:5];
        end
        req_half = !req_half;
      end
      if (cf_wait) check_flag("valid_o", valid_o, 1'b0);
      if (valid_o) begin
        check_flag("valid_o", 1'b1, shadow_hit(pc_o));
        check_word("inst_o", inst_o, exp_inst(pc_o));
        if (ready_i) begin
          check_addr("pc_o", pc_o, exp_pc);
          n_accept++;
          inst = exp_inst(exp_pc);
          if (is_fence_i(inst)) sh_valid = '0;
          if (is_ctrl_inst(inst)) begin
            cf_wait = 1'b1;
            mon_ctrl = 1'b1;
          end else begin
            exp_pc = exp_pc + 32'd4;
          end
        end
      end
      if (redirect_i) begin
        cf_wait = 1'b0;
        exp_pc = npc_i;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: only %0d of %0d instructions accepted", n_accept, NUM_INST);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    wait (n_accept >= NUM_INST);
    @(posedge clk);
    $display("%0d word errors, %0d address errors, %0d flag errors",
             n_word_err, n_addr_err, n_flag_err);
    if (n_word_err + n_addr_err + n_flag_err == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end
endmodule

/* verilog.f */
+incdir+source
source/ifu_pkg.sv
source/icache_if.sv
source/icache_array.sv
source/refill_counter.sv
source/fetch_fsm.sv
source/fetch_pc.sv
source/ifu_top.sv
tb/tb_ifu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = tb_ifu
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
